//--- spi_types_pkg.sv
/* SPI host data types
   Frame byte, bit counter and port engine states shared by all blocks */
`default_nettype none

package spi_types_pkg;

    // One serial frame, always a full byte
    typedef logic [7:0] spi_byte_t;

    // Bit index 0..7 plus the terminal count
    typedef logic [3:0] bit_count_t;

    // Number of bits in one frame, also the terminal bit count
    localparam bit_count_t FRAME_BITS = 4'd8;

    // Port engine FSM
    typedef enum logic [1:0] {
        LANE_IDLE   = 2'd0,  // Waiting for a start pulse
        LANE_SELECT = 2'd1,  // Chip select goes active, MSB on mosi
        LANE_SHIFT  = 2'd2,  // Eight serial clock periods
        LANE_FINISH = 2'd3   // Chip select released, back to idle
    } lane_state_t;

endpackage

`default_nettype wire

//--- spi_map_pkg.sv
/* SPI host port mapping
   Port number type and the default port count and serial clock divider */
`default_nettype none

package spi_map_pkg;

    // Port number, room for up to four ports
    typedef logic [1:0] lane_sel_t;

    localparam int DEFAULT_NUM_LANES = 4;

    // System clocks per serial clock period, even and at least 2
    localparam int DEFAULT_CLK_DIV = 4;

endpackage

`default_nettype wire

//--- spi_cmd_dispatch.sv
/* SPI command dispatcher
   Accepts a byte command for a free port and starts that port's engine */
`default_nettype none

module spi_cmd_dispatch #(
    parameter int NUM_LANES = spi_map_pkg::DEFAULT_NUM_LANES
) (
    input  wire                             clk,
    input  wire                             rst,
    input  wire                             cmd_start,
    input  wire spi_map_pkg::lane_sel_t     cmd_lane,
    input  wire spi_types_pkg::spi_byte_t   cmd_data,
    input  wire [NUM_LANES-1:0]             lane_busy,
    output logic [NUM_LANES-1:0]            lane_start,
    output spi_types_pkg::spi_byte_t        lane_data,
    output logic                            cmd_reject
);

    logic [NUM_LANES-1:0] target_onehot;
    logic                 target_free;

    // Out of range port numbers decode to no port and get rejected
    assign target_onehot = (int'(cmd_lane) < NUM_LANES) ?
                           (NUM_LANES'(1) << cmd_lane) : '0;

    // A start issued last cycle counts as busy until the engine raises busy
    assign target_free = |(target_onehot & ~(lane_busy | lane_start));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lane_start <= '0;
            cmd_reject <= 1'b0;
        end else begin
            lane_start <= '0;  // Pulses last one cycle
            cmd_reject <= 1'b0;
            if (cmd_start) begin
                if (target_free) begin
                    lane_start <= target_onehot;
                end else begin
                    cmd_reject <= 1'b1;  // Port busy, command dropped
                end
            end
        end
    end

    // Byte travels alongside the start pulse, shared by all engines
    always_ff @(posedge clk) begin
        if (cmd_start && target_free) begin
            lane_data <= cmd_data;
        end
    end

endmodule

`default_nettype wire

//--- spi_lane.sv
/* SPI mode 0 port engine
   Drives sclk, mosi and cs_n for one byte, MSB first, and captures miso */
`default_nettype none

module spi_lane #(
    parameter int CLK_DIV = spi_map_pkg::DEFAULT_CLK_DIV
) (
    input  wire                             clk,
    input  wire                             rst,
    input  wire                             start,
    input  wire spi_types_pkg::spi_byte_t   tx_data,
    input  wire                             miso,
    output logic                            sclk,
    output logic                            mosi,
    output logic                            cs_n,
    output logic                            busy,
    output logic                            done,
    output spi_types_pkg::spi_byte_t        rx_data
);

    import spi_types_pkg::*;

    localparam int DIV_W = $clog2(CLK_DIV);
    localparam logic [DIV_W-1:0] DIV_MID = DIV_W'(CLK_DIV / 2 - 1);  // sclk rises here
    localparam logic [DIV_W-1:0] DIV_END = DIV_W'(CLK_DIV - 1);      // sclk falls here

    lane_state_t      state;
    logic [DIV_W-1:0] div_cnt;
    bit_count_t       bit_cnt;
    spi_byte_t        tx_shift;
    spi_byte_t        rx_shift;

    logic             accept;
    logic             at_mid;
    logic             at_end;
    logic             last_bit;

    assign accept   = (state == LANE_IDLE) && start;
    assign at_mid   = (state == LANE_SHIFT) && (div_cnt == DIV_MID);
    assign at_end   = (state == LANE_SHIFT) && (div_cnt == DIV_END);
    assign last_bit = (bit_cnt == bit_count_t'(FRAME_BITS - 4'd1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= LANE_IDLE;
            div_cnt <= '0;
            bit_cnt <= '0;
            sclk    <= 1'b0;
            mosi    <= 1'b0;
            cs_n    <= 1'b1;
            busy    <= 1'b0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                LANE_IDLE: begin
                    if (start) begin
                        busy  <= 1'b1;
                        state <= LANE_SELECT;
                    end
                end
                LANE_SELECT: begin
                    cs_n    <= 1'b0;
                    mosi    <= tx_shift[7];  // First bit ahead of the first rise
                    div_cnt <= '0;
                    bit_cnt <= '0;
                    state   <= LANE_SHIFT;
                end
                LANE_SHIFT: begin
                    div_cnt <= div_cnt + 1'b1;
                    if (at_mid) begin
                        sclk <= 1'b1;
                    end
                    if (at_end) begin
                        div_cnt <= '0;
                        sclk    <= 1'b0;
                        bit_cnt <= bit_cnt + 1'b1;  // Ends at the terminal count
                        if (last_bit) begin
                            // Frame complete, release the slave
                            cs_n  <= 1'b1;
                            mosi  <= 1'b0;
                            busy  <= 1'b0;
                            done  <= 1'b1;
                            state <= LANE_FINISH;
                        end else begin
                            mosi <= tx_shift[6];  // Next bit on the falling edge
                        end
                    end
                end
                LANE_FINISH: begin
                    state <= LANE_IDLE;
                end
                default: state <= LANE_IDLE;
            endcase
        end
    end

    // Shift registers and received byte
    always_ff @(posedge clk) begin
        if (accept) begin
            tx_shift <= tx_data;
        end else if (at_end) begin
            tx_shift <= {tx_shift[6:0], 1'b0};
        end

        if (at_mid) begin
            rx_shift <= {rx_shift[6:0], miso};  // Sample on the rising edge
        end

        if (at_end && last_bit) begin
            rx_data <= rx_shift;
        end
    end

endmodule

`default_nettype wire

//--- spi_rx_collect.sv
/* SPI receive collector
   Reports each finished transfer and keeps the last byte of every port */
`default_nettype none

module spi_rx_collect #(
    parameter int NUM_LANES = spi_map_pkg::DEFAULT_NUM_LANES
) (
    input  wire                                         clk,
    input  wire                                         rst,
    input  wire [NUM_LANES-1:0]                         lane_done,
    input  wire spi_types_pkg::spi_byte_t [NUM_LANES-1:0] lane_rx,
    input  wire spi_map_pkg::lane_sel_t                 rd_lane,
    output logic                                        done,
    output spi_map_pkg::lane_sel_t                      done_lane,
    output spi_types_pkg::spi_byte_t                    done_data,
    output spi_types_pkg::spi_byte_t                    rd_data
);

    import spi_types_pkg::*;
    import spi_map_pkg::*;

    logic      any_done;
    lane_sel_t done_sel;
    spi_byte_t done_byte;
    spi_byte_t shadow [NUM_LANES];

    // At most one engine finishes per cycle, so a plain encoder is enough
    always_comb begin
        any_done  = |lane_done;
        done_sel  = '0;
        done_byte = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            if (lane_done[i]) begin
                done_sel  = lane_sel_t'(i);
                done_byte = lane_rx[i];
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            done <= 1'b0;
            for (int i = 0; i < NUM_LANES; i++) begin
                shadow[i] <= '0;
            end
        end else begin
            done <= any_done;
            if (any_done) begin
                shadow[done_sel] <= done_byte;
            end
        end
    end

    // Report fields, valid while done is high
    always_ff @(posedge clk) begin
        if (any_done) begin
            done_lane <= done_sel;
            done_data <= done_byte;
        end
    end

    assign rd_data = (int'(rd_lane) < NUM_LANES) ? shadow[rd_lane] : '0;  // Unused ports read 0

endmodule

`default_nettype wire

//--- spi_multi_host.sv
/* Multi-port SPI host top level
   Dispatcher, one mode 0 engine per port, and the receive collector */
`default_nettype none

module spi_multi_host #(
    parameter int NUM_LANES = spi_map_pkg::DEFAULT_NUM_LANES,
    parameter int CLK_DIV   = spi_map_pkg::DEFAULT_CLK_DIV
) (
    input  wire                             clk,
    input  wire                             rst,
    input  wire                             cmd_start,
    input  wire spi_map_pkg::lane_sel_t     cmd_lane,
    input  wire spi_types_pkg::spi_byte_t   cmd_data,
    input  wire spi_map_pkg::lane_sel_t     rd_lane,
    input  wire [NUM_LANES-1:0]             miso,
    output wire                             cmd_reject,
    output wire [NUM_LANES-1:0]             lane_busy,
    output wire [NUM_LANES-1:0]             sclk,
    output wire [NUM_LANES-1:0]             mosi,
    output wire [NUM_LANES-1:0]             cs_n,
    output wire                             done,
    output wire spi_map_pkg::lane_sel_t     done_lane,
    output wire spi_types_pkg::spi_byte_t   done_data,
    output wire spi_types_pkg::spi_byte_t   rd_data
);

    import spi_types_pkg::*;

    wire [NUM_LANES-1:0]            lane_start;
    wire spi_byte_t                 lane_data;   // Shared by all engines
    wire [NUM_LANES-1:0]            lane_done;
    wire spi_byte_t [NUM_LANES-1:0] lane_rx;

    spi_cmd_dispatch #(
        .NUM_LANES (NUM_LANES)
    ) u_dispatch (
        .clk        (clk),
        .rst        (rst),
        .cmd_start  (cmd_start),
        .cmd_lane   (cmd_lane),
        .cmd_data   (cmd_data),
        .lane_busy  (lane_busy),
        .lane_start (lane_start),
        .lane_data  (lane_data),
        .cmd_reject (cmd_reject)
    );

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        spi_lane #(
            .CLK_DIV (CLK_DIV)
        ) u_lane (
            .clk     (clk),
            .rst     (rst),
            .start   (lane_start[i]),
            .tx_data (lane_data),
            .miso    (miso[i]),
            .sclk    (sclk[i]),
            .mosi    (mosi[i]),
            .cs_n    (cs_n[i]),
            .busy    (lane_busy[i]),
            .done    (lane_done[i]),
            .rx_data (lane_rx[i])
        );
    end

    spi_rx_collect #(
        .NUM_LANES (NUM_LANES)
    ) u_collect (
        .clk       (clk),
        .rst       (rst),
        .lane_done (lane_done),
        .lane_rx   (lane_rx),
        .rd_lane   (rd_lane),
        .done      (done),
        .done_lane (done_lane),
        .done_data (done_data),
        .rd_data   (rd_data)
    );

endmodule

`default_nettype wire

//--- tb_spi_multi_host.sv
/* Testbench for the multi-port SPI host
   Directed tests against one SPI slave model per port */
`default_nettype none

module tb_spi_multi_host;

    import spi_types_pkg::*;
    import spi_map_pkg::*;

    localparam int NUM_LANES       = 4;
    localparam int CLK_DIV         = 4;
    localparam int XFER_LATENCY    = 4 + 8 * CLK_DIV;  // Command edge to done
    localparam int WATCHDOG_CYCLES = 10 + 10 * (XFER_LATENCY + 12);

    logic                          clk;
    logic                          rst;
    logic                          cmd_start;
    lane_sel_t                     cmd_lane;
    spi_byte_t                     cmd_data;
    lane_sel_t                     rd_lane;
    wire  [NUM_LANES-1:0]          miso;
    wire                           cmd_reject;
    wire  [NUM_LANES-1:0]          lane_busy;
    wire  [NUM_LANES-1:0]          sclk;
    wire  [NUM_LANES-1:0]          mosi;
    wire  [NUM_LANES-1:0]          cs_n;
    wire                           done;
    lane_sel_t                     done_lane;
    spi_byte_t                     done_data;
    spi_byte_t                     rd_data;

    logic [NUM_LANES-1:0][7:0]     slave_resp;    // Byte each slave sends back
    wire  [NUM_LANES-1:0][7:0]     slave_cap;     // Byte each slave received
    logic [NUM_LANES-1:0][7:0]     shadow_model;  // Expected shadow registers
    logic [7:0]                    lfsr = 8'd30;
    int                            cycle_count = 0;
    int                            error_count = 0;
    int                            tests_run = 0;
    int                            tests_failed = 0;

    spi_multi_host #(
        .NUM_LANES (NUM_LANES),
        .CLK_DIV   (CLK_DIV)
    ) dut (
        .clk        (clk),
        .rst        (rst),
        .cmd_start  (cmd_start),
        .cmd_lane   (cmd_lane),
        .cmd_data   (cmd_data),
        .rd_lane    (rd_lane),
        .miso       (miso),
        .cmd_reject (cmd_reject),
        .lane_busy  (lane_busy),
        .sclk       (sclk),
        .mosi       (mosi),
        .cs_n       (cs_n),
        .done       (done),
        .done_lane  (done_lane),
        .done_data  (done_data),
        .rd_data    (rd_data)
    );

    // Mode 0 slave per port, miso shifts on the falling sclk edge
    for (genvar i = 0; i < NUM_LANES; i++) begin : g_slave
        logic       so;
        logic [7:0] tx;
        logic [7:0] cap;
        assign miso[i]      = so;
        assign slave_cap[i] = cap;
        initial begin
            so  = 1'b0;
            tx  = '0;
            cap = '0;
            forever begin
                @(negedge cs_n[i]);
                tx  = slave_resp[i];
                cap = '0;
                so  = tx[7];  // MSB ready before the first rise
                repeat (8) begin
                    @(posedge sclk[i]);
                    cap = {cap[6:0], mosi[i]};
                    @(negedge sclk[i]);
                    tx = {tx[6:0], 1'b0};
                    so = tx[7];
                end
            end
        end
    end

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) cycle_count <= cycle_count + 1;

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("ERROR: watchdog expired after %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    function automatic logic [7:0] lfsr_step(input logic [7:0] state);
        return state[0] ? ((state >> 1) ^ 8'hB8) : (state >> 1);  // Galois taps 8,6,5,4
    endfunction

    task automatic random_byte(output spi_byte_t value);
        value = '0;
        for (int b = 0; b < 8; b++) begin
            value = {value[6:0], lfsr[0]};
            lfsr  = lfsr_step(lfsr);
        end
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] actual,
                                   input logic [31:0] expected);
        $display("MISMATCH at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
        error_count++;
    endtask

    task automatic report_failure(input string what);
        $display("ERROR at %0t: %s", $time, what);
        error_count++;
    endtask

    task automatic finish_test(input string name, input int start_errors);
        tests_run++;
        if (error_count == start_errors) begin
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: FAILED with %0d errors", name, error_count - start_errors);
        end
    endtask

    // Returns the cycle count after the edge that raises cmd_start
    task automatic drive_cmd(input int lane, input spi_byte_t value, output int issued);
        @(negedge clk);
        issued = cycle_count + 1;
        @(posedge clk);
        cmd_start <= 1'b1;
        cmd_lane  <= lane_sel_t'(lane);
        cmd_data  <= value;
    endtask

    task automatic release_cmd();
        @(posedge clk);
        cmd_start <= 1'b0;
    endtask

    // A negative lane skips the chip select check
    task automatic wait_done(input int lane, output int finished);
        logic [NUM_LANES-1:0] own;
        bit                   flagged;
        own      = (lane >= 0) ? NUM_LANES'(1) << lane : '0;
        flagged  = 1'b0;
        finished = -1;
        for (int waited = 0; waited < XFER_LATENCY + 8; waited++) begin
            @(negedge clk);
            if (lane >= 0 && !flagged && (cs_n | own) !== '1) begin
                report_mismatch("cs_n", 32'(cs_n), 32'(~own));
                flagged = 1'b1;
            end
            if (done === 1'b1) begin
                finished = cycle_count;
                break;
            end
        end
        if (finished < 0) report_failure("no done pulse before the timeout");
    endtask

    task automatic check_done(input int lane, input int issued, input int finished,
                              input spi_byte_t tx_byte, input spi_byte_t resp);
        if (finished >= 0 && finished - issued != XFER_LATENCY)
            report_mismatch("done latency", 32'(finished - issued), 32'(XFER_LATENCY));
        if (done_lane !== lane_sel_t'(lane))
            report_mismatch("done_lane", 32'(done_lane), 32'(lane));
        if (done_data !== resp)
            report_mismatch("done_data", 32'(done_data), 32'(resp));
        if (slave_cap[lane] !== tx_byte)
            report_mismatch("slave captured byte", 32'(slave_cap[lane]), 32'(tx_byte));
        shadow_model[lane] = resp;
    endtask

    task automatic run_transfer(input int lane);
        spi_byte_t tx_byte;
        spi_byte_t resp;
        int        issued;
        int        finished;
        random_byte(tx_byte);
        random_byte(resp);
        slave_resp[lane] = resp;
        drive_cmd(lane, tx_byte, issued);
        release_cmd();
        wait_done(lane, finished);
        check_done(lane, issued, finished, tx_byte, resp);
    endtask

    task automatic test_reset_state();
        int start_errors;
        start_errors = error_count;
        @(negedge clk);
        if (sclk !== '0) report_mismatch("sclk", 32'(sclk), 32'(0));
        if (cs_n !== '1) report_mismatch("cs_n", 32'(cs_n), 32'(4'hF));
        if (mosi !== '0) report_mismatch("mosi", 32'(mosi), 32'(0));
        if (done !== 1'b0) report_mismatch("done", 32'(done), 32'(0));
        if (cmd_reject !== 1'b0) report_mismatch("cmd_reject", 32'(cmd_reject), 32'(0));
        if (lane_busy !== '0) report_mismatch("lane_busy", 32'(lane_busy), 32'(0));
        for (int i = 0; i < NUM_LANES; i++) begin
            @(posedge clk);
            rd_lane <= lane_sel_t'(i);
            @(negedge clk);
            if (rd_data !== '0) report_mismatch("rd_data", 32'(rd_data), 32'(0));
        end
        finish_test("reset state", start_errors);
    endtask

    task automatic test_single_port();
        int start_errors;
        start_errors = error_count;
        run_transfer(0);
        finish_test("single transfer on port 0", start_errors);
    endtask

    task automatic test_each_port();
        int start_errors;
        start_errors = error_count;
        for (int i = 0; i < NUM_LANES; i++) run_transfer(i);
        finish_test("each port in turn", start_errors);
    endtask

    task automatic test_busy_reject();
        spi_byte_t first_tx;
        spi_byte_t second_tx;
        spi_byte_t resp;
        int        issued;
        int        ignored;
        int        finished;
        int        start_errors;
        start_errors = error_count;
        random_byte(first_tx);
        random_byte(second_tx);
        random_byte(resp);
        slave_resp[2] = resp;
        drive_cmd(2, first_tx, issued);
        release_cmd();
        repeat (4) @(posedge clk);
        drive_cmd(2, second_tx, ignored);  // Port 2 is busy by now
        release_cmd();
        @(negedge clk);
        if (cmd_reject !== 1'b1) report_failure("command to a busy port was not rejected");
        @(negedge clk);
        if (cmd_reject !== 1'b0) report_failure("cmd_reject stayed high past one cycle");
        wait_done(2, finished);
        check_done(2, issued, finished, first_tx, resp);
        for (int i = 0; i < XFER_LATENCY + 8; i++) begin
            @(negedge clk);
            if (done === 1'b1) report_failure("a rejected command produced a done pulse");
        end
        finish_test("busy reject", start_errors);
    endtask

    task automatic test_overlap();
        spi_byte_t tx_bytes [NUM_LANES];
        spi_byte_t resp [NUM_LANES];
        int        issued [NUM_LANES];
        int        finished;
        int        start_errors;
        start_errors = error_count;
        for (int i = 0; i < NUM_LANES; i++) begin
            random_byte(tx_bytes[i]);
            random_byte(resp[i]);
            slave_resp[i] = resp[i];
        end
        for (int i = 0; i < NUM_LANES; i++) drive_cmd(i, tx_bytes[i], issued[i]);
        release_cmd();
        // Exact latency from back to back commands gives back to back done pulses
        for (int i = 0; i < NUM_LANES; i++) begin
            wait_done(-1, finished);
            check_done(i, issued[i], finished, tx_bytes[i], resp[i]);
        end
        finish_test("overlapping ports", start_errors);
    endtask

    task automatic test_shadow_readback();
        int start_errors;
        start_errors = error_count;
        for (int i = 0; i < NUM_LANES; i++) begin
            @(posedge clk);
            rd_lane <= lane_sel_t'(i);
            @(negedge clk);
            if (rd_data !== shadow_model[i])
                report_mismatch("rd_data", 32'(rd_data), 32'(shadow_model[i]));
        end
        finish_test("shadow readback", start_errors);
    endtask

    initial begin
        rst          = 1'b1;
        cmd_start    = 1'b0;
        cmd_lane     = '0;
        cmd_data     = '0;
        rd_lane      = '0;
        slave_resp   = '0;
        shadow_model = '0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        test_reset_state();
        test_single_port();
        test_each_port();
        test_busy_reject();
        test_overlap();
        test_shadow_readback();
        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- spi_multi_host.f
spi_types_pkg.sv
spi_map_pkg.sv
spi_cmd_dispatch.sv
spi_lane.sv
spi_rx_collect.sv
spi_multi_host.sv
tb_spi_multi_host.sv

//--- Makefile
# Verilator build and run of the multi-port SPI host testbench
TOP = tb_spi_multi_host

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --top-module $(TOP) -f spi_multi_host.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir
